// File: ex_subsystem.f
+incdir+include
hdl/ex_types_pkg.sv
hdl/ex_pipe_pkg.sv
hdl/alu.sv
hdl/mult_unit.sv
hdl/stage_ex.sv
hdl/ex_subsystem.sv
testbench/tb_ex_subsystem.sv

// File: hdl/alu.sv
// combinational integer alu of the execute stage, flags signed overflow and reserved opcodes
`timescale 1ns/1ps

module alu #(
	parameter int data_width = 32
) (
	input  logic [data_width-1:0] opr1,
	input  logic [data_width-1:0] opr2,
	input  logic [4:0]            sa,
	input  ex_types_pkg::alu_op_e op,
	output logic [data_width-1:0] result,
	output logic                  overflow,
	output logic                  illegal_op
);

	localparam int msb = data_width - 1;

	logic [data_width-1:0] sum;
	logic [data_width-1:0] diff;
	logic                  add_ovf;
	logic                  sub_ovf;

	assign sum  = opr1 + opr2;
	assign diff = opr1 - opr2;

	// operands of equal sign must give a result of that sign
	assign add_ovf = (opr1[msb] == opr2[msb]) && (sum[msb] != opr1[msb]);
	// operands of opposite sign must not flip the sign of opr1
	assign sub_ovf = (opr1[msb] != opr2[msb]) && (diff[msb] != opr1[msb]);

	always_comb begin
		result     = '0;
		overflow   = 1'b0;
		illegal_op = 1'b0;
		case (op)
			ex_types_pkg::alu_add: begin
				result   = sum;
				overflow = add_ovf;
			end
			ex_types_pkg::alu_addu: result = sum;
			ex_types_pkg::alu_sub: begin
				result   = diff;
				overflow = sub_ovf;
			end
			ex_types_pkg::alu_subu: result = diff;
			ex_types_pkg::alu_and:  result = opr1 & opr2;
			ex_types_pkg::alu_or:   result = opr1 | opr2;
			ex_types_pkg::alu_xor:  result = opr1 ^ opr2;
			ex_types_pkg::alu_nor:  result = ~(opr1 | opr2);
			ex_types_pkg::alu_slt: begin
				result = {{(data_width-1){1'b0}}, $signed(opr1) < $signed(opr2)};
			end
			ex_types_pkg::alu_sltu: begin
				result = {{(data_width-1){1'b0}}, opr1 < opr2};
			end
			ex_types_pkg::alu_sll:    result = opr2 << sa;
			ex_types_pkg::alu_srl:    result = opr2 >> sa;
			ex_types_pkg::alu_sra:    result = $signed(opr2) >>> sa; // keeps the sign bit
			ex_types_pkg::alu_lui:    result = opr2 << 16;
			ex_types_pkg::alu_pass_b: result = opr2;
			ex_types_pkg::alu_mult:   result = '0; // product goes to the multiplier instead
			default:                  illegal_op = 1'b1;
		endcase
	end

endmodule

// File: hdl/ex_pipe_pkg.sv
// packed interstage records and multiplier handshake records of the execute stage
package ex_pipe_pkg;

	// decoded instruction as handed over by decode
	typedef struct packed {
		ex_types_pkg::alu_op_e    alu_op;
		logic                     alu_src_imm;     // operand b comes from sa_imm
		logic [31:0]              sa_imm;          // low five bits double as shift amount
		ex_types_pkg::branch_op_e branch_op;
		logic [31:0]              branch_dest;
		logic                     branch_dest_reg; // destination is reg2 instead of branch_dest
		ex_types_pkg::mem_op_e    mem_op;
		logic [4:0]               wb_addr;
		ex_types_pkg::exc_code_e  exc_code;
		logic [31:0]              exc_epc;
		logic [31:0]              exc_badvaddr;
	} id2ex_t;

	// record forwarded to the memory stage
	typedef struct packed {
		ex_types_pkg::mem_op_e   mem_op;
		logic [4:0]              wb_addr;
		logic [31:0]             alu_result;
		logic [31:0]             mem_addr;
		logic [31:0]             mem_data; // store data, taken from reg2
		ex_types_pkg::exc_code_e exc_code;
		logic [31:0]             exc_epc;
		logic [31:0]             exc_badvaddr;
	} ex2mem_t;

	typedef struct packed {
		logic [31:0] opr1;
		logic [31:0] opr2;
	} mult_req_t;

	// hi holds the upper half of the unsigned product
	typedef struct packed {
		logic [31:0] hi;
		logic [31:0] lo;
	} mult_rsp_t;

endpackage

// File: hdl/ex_subsystem.sv
// top level of the execute subsystem, joins the execute stage and the multiplier
`timescale 1ns/1ps

module ex_subsystem #(
	parameter int data_width = 32
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stall,
	input  logic                  clear,
	input  ex_pipe_pkg::id2ex_t   id2ex,
	input  logic [data_width-1:0] reg1_data,
	input  logic [data_width-1:0] reg2_data,
	output logic                  branch_flag,
	output logic [data_width-1:0] branch_dest,
	output ex_pipe_pkg::ex2mem_t  ex2mem,
	output logic [31:0]           hi,
	output logic [31:0]           lo,
	output logic                  mult_busy
);

	logic                   mult_req;
	logic                   mult_ack;
	ex_pipe_pkg::mult_req_t mult_req_data;
	ex_pipe_pkg::mult_rsp_t mult_rsp;

	stage_ex #(.data_width(data_width)) i_stage_ex (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall         (stall),
		.clear         (clear),
		.id2ex         (id2ex),
		.reg1_data     (reg1_data),
		.reg2_data     (reg2_data),
		.branch_flag   (branch_flag),
		.branch_dest   (branch_dest),
		.ex2mem        (ex2mem),
		.mult_req      (mult_req),
		.mult_req_data (mult_req_data),
		.mult_ack      (mult_ack)
	);

	mult_unit #(.data_width(data_width)) i_mult_unit (
		.clk      (clk),
		.rst_n    (rst_n),
		.req      (mult_req),
		.req_data (mult_req_data),
		.ack      (mult_ack),
		.rsp      (mult_rsp)
	);

	assign hi        = mult_rsp.hi;
	assign lo        = mult_rsp.lo;
	assign mult_busy = mult_req | mult_ack; // environment stalls a second mult on this
endmodule

// File: hdl/ex_types_pkg.sv
// opcode and code enums for the execute stage, referenced by scoped name from RTL and testbench
package ex_types_pkg;

	// alu opcodes, every code above alu_mult is a reserved instruction
	typedef enum logic [4:0] {
		alu_add    = 5'd0,
		alu_addu   = 5'd1,
		alu_sub    = 5'd2,
		alu_subu   = 5'd3,
		alu_and    = 5'd4,
		alu_or     = 5'd5,
		alu_xor    = 5'd6,
		alu_nor    = 5'd7,
		alu_slt    = 5'd8,
		alu_sltu   = 5'd9,
		alu_sll    = 5'd10,
		alu_srl    = 5'd11,
		alu_sra    = 5'd12,
		alu_lui    = 5'd13,
		alu_pass_b = 5'd14,
		alu_mult   = 5'd15
	} alu_op_e;

	typedef enum logic [1:0] {
		br_none   = 2'd0,
		br_eqz    = 2'd1, // taken when the alu result is zero
		br_nez    = 2'd2, // taken when the alu result is not zero
		br_uncond = 2'd3
	} branch_op_e;

	typedef enum logic [2:0] {
		mem_none = 3'd0,
		mem_lw   = 3'd1,
		mem_lb   = 3'd2,
		mem_sw   = 3'd3,
		mem_sb   = 3'd4
	} mem_op_e;

	// ri and ov are raised here, the rest come from decode unchanged
	typedef enum logic [4:0] {
		exc_none    = 5'd0,
		exc_ri      = 5'd1,
		exc_ov      = 5'd2,
		exc_syscall = 5'd3,
		exc_break   = 5'd4,
		exc_adel    = 5'd5,
		exc_ades    = 5'd6
	} exc_code_e;

	localparam logic [3:0] ri_badvaddr_tag = 4'hf; // marks badvaddr as holding an opcode

endpackage

// File: hdl/mult_unit.sv
// iterative unsigned shift-add multiplier answering a four-phase req/ack handshake
`timescale 1ns/1ps

module mult_unit #(
	parameter int data_width = 32
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   req,
	input  ex_pipe_pkg::mult_req_t req_data,
	output logic                   ack,
	output ex_pipe_pkg::mult_rsp_t rsp
);

	localparam int cnt_w = $clog2(data_width);

	typedef enum logic [1:0] {
		mu_idle,
		mu_run,
		mu_done
	} mult_state_e;

	mult_state_e             state;
	logic [cnt_w-1:0]        count;
	logic [2*data_width-1:0] acc;
	logic [2*data_width-1:0] mcand;   // shifted left once per step
	logic [data_width-1:0]   mplier;  // shifted right once per step
	logic [2*data_width-1:0] acc_next;

	assign acc_next = mplier[0] ? acc + mcand : acc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state  <= mu_idle;
			ack    <= 1'b0;
			rsp.hi <= '0;
			rsp.lo <= '0;
		end else begin
			case (state)
				mu_idle: begin
					if (req) begin
						state  <= mu_run;
						count  <= '0;
						acc    <= '0;
						mcand  <= {{data_width{1'b0}}, req_data.opr1};
						mplier <= req_data.opr2;
					end
				end
				mu_run: begin
					acc    <= acc_next;
					mcand  <= mcand << 1;
					mplier <= mplier >> 1;
					count  <= count + 1'b1;
					if (count == cnt_w'(data_width - 1)) begin // last partial product
						rsp.hi <= acc_next[2*data_width-1:data_width];
						rsp.lo <= acc_next[data_width-1:0];
						ack    <= 1'b1;
						state  <= mu_done;
					end
				end
				mu_done: begin
					if (!req) begin // requester has seen ack
						ack   <= 1'b0;
						state <= mu_idle;
					end
				end
				default: state <= mu_idle;
			endcase
		end
	end

endmodule

// File: hdl/stage_ex.sv
// execute stage register with branch resolution, exception priority and multiplier requester
`timescale 1ns/1ps

module stage_ex #(
	parameter int data_width = 32
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall,
	input  logic                   clear,
	input  ex_pipe_pkg::id2ex_t    id2ex,
	input  logic [data_width-1:0]  reg1_data,
	input  logic [data_width-1:0]  reg2_data,
	output logic                   branch_flag,
	output logic [data_width-1:0]  branch_dest,
	output ex_pipe_pkg::ex2mem_t   ex2mem,
	output logic                   mult_req,
	output ex_pipe_pkg::mult_req_t mult_req_data,
	input  logic                   mult_ack
);

	typedef enum logic [1:0] {
		ms_idle,
		ms_req,
		ms_wait_ack_low
	} mult_state_e;

	mult_state_e             mult_state;
	logic [data_width-1:0]   alu_opr2;
	logic [data_width-1:0]   alu_result;
	logic                    alu_overflow;
	logic                    alu_illegal;
	logic                    branch_flag_next;
	logic [data_width-1:0]   branch_dest_next;
	ex_types_pkg::exc_code_e exc_next;
	logic [31:0]             badvaddr_next;
	logic                    accept;
	logic                    mult_start;

	assign alu_opr2 = id2ex.alu_src_imm ? id2ex.sa_imm : reg2_data;

	alu #(.data_width(data_width)) i_alu (
		.opr1       (reg1_data),
		.opr2       (alu_opr2),
		.sa         (id2ex.sa_imm[4:0]),
		.op         (id2ex.alu_op),
		.result     (alu_result),
		.overflow   (alu_overflow),
		.illegal_op (alu_illegal)
	);

	assign branch_flag_next = (id2ex.branch_op == ex_types_pkg::br_eqz && alu_result == '0) ||
		(id2ex.branch_op == ex_types_pkg::br_nez && alu_result != '0) ||
		(id2ex.branch_op == ex_types_pkg::br_uncond);
	assign branch_dest_next = id2ex.branch_dest_reg ? reg2_data : id2ex.branch_dest;

	// an exception from decode wins over anything found here
	always_comb begin
		exc_next      = id2ex.exc_code;
		badvaddr_next = id2ex.exc_badvaddr;
		if (id2ex.exc_code == ex_types_pkg::exc_none) begin
			if (alu_illegal) begin
				exc_next      = ex_types_pkg::exc_ri;
				badvaddr_next = {ex_types_pkg::ri_badvaddr_tag,
					{(28-$bits(ex_types_pkg::alu_op_e)){1'b0}}, id2ex.alu_op};
			end else if (alu_overflow) begin
				exc_next = ex_types_pkg::exc_ov;
			end
		end
	end

	assign accept     = !stall && !clear;
	// a second mult while the handshake is still busy is dropped here
	assign mult_start = accept && id2ex.alu_op == ex_types_pkg::alu_mult &&
		exc_next == ex_types_pkg::exc_none && !mult_ack && mult_state != ms_req;

	always_ff @(posedge clk) begin // branch outputs follow every cycle, stall or not
		if (!rst_n) begin
			branch_flag <= 1'b0;
			branch_dest <= '0;
		end else begin
			branch_flag <= branch_flag_next;
			branch_dest <= branch_dest_next;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex2mem.mem_op   <= ex_types_pkg::mem_none;
			ex2mem.wb_addr  <= '0;
			ex2mem.exc_code <= ex_types_pkg::exc_none;
		end else if (!stall) begin
			ex2mem.mem_op   <= ex_types_pkg::mem_none; // bubble unless an instruction is taken
			ex2mem.wb_addr  <= '0;
			ex2mem.exc_code <= ex_types_pkg::exc_none;
			if (!clear) begin
				ex2mem.exc_code     <= exc_next;
				ex2mem.exc_epc      <= id2ex.exc_epc;
				ex2mem.exc_badvaddr <= badvaddr_next;
				ex2mem.alu_result   <= alu_result;
				ex2mem.mem_addr     <= alu_result;
				ex2mem.mem_data     <= reg2_data;
				if (exc_next == ex_types_pkg::exc_none) begin
					ex2mem.mem_op  <= id2ex.mem_op;
					ex2mem.wb_addr <= id2ex.wb_addr;
				end
			end
		end
	end

	// requester side of the four-phase handshake
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mult_state <= ms_idle;
		end else if (mult_start) begin
			mult_state         <= ms_req;
			mult_req_data.opr1 <= reg1_data;
			mult_req_data.opr2 <= reg2_data;
		end else begin
			case (mult_state)
				ms_req:          if (mult_ack) mult_state <= ms_wait_ack_low;
				ms_wait_ack_low: if (!mult_ack) mult_state <= ms_idle;
				default:         mult_state <= ms_idle;
			endcase
		end
	end

	assign mult_req = (mult_state == ms_req);

endmodule

// File: run_sim.sh
#!/bin/sh
# builds the execute subsystem testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ex_subsystem -f ex_subsystem.f -o sim_ex

./obj_dir/sim_ex > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
	exit 1
fi
grep -q "Done: no errors" sim.log

// File: testbench/ex_stim.txt
// test op imm sa_imm bop bdest bdreg mem_op wb exc epc badvaddr reg1 reg2 stall clear, then
// expected alu_result exc_code branch_flag branch_dest hi lo, all hex, test 0 ends the list
1 0 0 0 0 0 0 1 3 0 400 0 5 3 0 0 8 0 0 0 0 0
2 1 1 10 0 0 0 0 4 0 404 0 20 7 0 0 30 0 0 0 0 0
3 2 0 0 1 1000 0 0 5 0 408 0 10 3 0 0 d 0 0 1000 0 0
4 3 0 0 0 0 0 0 6 0 40c 0 3 5 0 0 fffffffe 0 0 0 0 0
5 4 0 0 0 0 0 0 7 0 410 0 f0f0 ff00 0 0 f000 0 0 0 0 0
6 5 1 f 0 0 0 0 8 0 414 0 f0 0 0 0 ff 0 0 0 0 0
7 6 0 0 0 0 0 0 9 0 418 0 ff f 0 0 f0 0 0 0 0 0
8 7 0 0 0 0 0 0 a 0 41c 0 0 0 0 0 ffffffff 0 0 0 0 0
9 8 0 0 2 2000 0 0 b 0 420 0 ffffffff 1 0 0 1 0 1 2000 0 0
a 9 0 0 1 3000 1 0 c 0 424 0 ffffffff 1 0 0 0 0 1 1 0 0
b a 0 4 0 0 0 0 d 0 428 0 0 3 0 0 30 0 0 0 0 0
c b 0 8 0 0 0 0 e 0 42c 0 0 80000000 0 0 800000 0 0 0 0 0
d c 0 8 0 0 0 0 f 0 430 0 0 80000000 0 0 ff800000 0 0 0 0 0
e d 1 1234 0 0 0 0 10 0 434 0 0 0 0 0 12340000 0 0 0 0 0
f e 0 0 3 4000 0 3 11 0 438 0 0 cafe 0 0 cafe 0 1 4000 0 0
10 0 0 0 0 0 0 1 5 3 43c 0 1 2 0 0 3 3 0 0 0 0
11 10 0 0 0 0 0 1 6 5 440 1001 1 2 0 0 0 5 0 0 0 0
12 1f 0 0 0 0 0 3 7 0 444 0 1 2 0 0 0 1 0 0 0 0
13 11 0 0 0 0 0 0 8 0 448 0 0 0 0 0 0 1 0 0 0 0
14 0 0 0 0 0 0 0 9 0 44c 0 7fffffff 1 0 0 80000000 2 0 0 0 0
15 1 0 0 0 0 0 0 9 0 450 0 7fffffff 1 0 0 80000000 0 0 0 0 0
16 2 0 0 0 0 0 0 a 0 454 0 80000000 1 0 0 7fffffff 2 0 0 0 0
17 3 0 0 0 0 0 0 a 0 458 0 80000000 1 0 0 7fffffff 0 0 0 0 0
18 0 0 0 1 5000 0 0 b 0 45c 0 80000000 80000000 0 0 0 2 1 5000 0 0
19 3 0 0 1 6000 0 0 c 0 460 0 5 5 0 0 0 0 1 6000 0 0
1a 3 0 0 2 6000 1 0 c 0 464 0 5 5 0 0 0 0 0 5 0 0
1b e 0 0 3 0 1 0 d 0 468 0 0 8000 0 0 8000 0 1 8000 0 0
1c 1 0 0 0 0 0 1 e 0 46c 0 100 1 0 0 101 0 0 0 0 0
1d 0 0 0 3 7000 0 0 f 0 470 0 2 2 1 0 101 0 1 7000 0 0
1e 1f 0 0 1 0 1 0 f 0 474 0 2 9 1 1 101 0 1 9 0 0
1f 0 0 0 2 7100 0 1 10 0 478 0 3 3 0 1 101 0 1 7100 0 0
20 0 0 0 0 0 0 1 11 3 47c 0 1 1 0 1 101 0 0 0 0 0
21 5 0 0 0 0 0 2 12 0 480 0 1 2 0 0 3 0 0 0 0 0
22 f 0 0 0 0 0 0 0 0 484 0 3 5 0 0 0 0 0 0 0 f
23 f 0 0 0 0 0 0 0 0 488 0 ffffffff ffffffff 0 0 0 0 0 0 fffffffe 1
24 f 0 0 0 0 0 0 0 0 48c 0 12345678 10 0 0 0 0 0 0 1 23456780
25 1 0 0 0 0 0 0 1 0 490 0 1 1 0 0 2 0 0 0 1 23456780
26 f 0 0 0 0 0 0 0 4 494 0 2 3 0 0 0 4 0 0 1 23456780
27 f 1 7 0 0 0 0 0 0 498 0 80000000 2 0 0 0 0 0 0 1 0
28 a 0 1f 0 0 0 0 13 0 49c 0 0 1 0 0 80000000 0 0 0 1 0
0

// File: include/tb_ex_model.svh
// reference model functions for the execute stage, included inside the testbench module
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// expected alu result, zero for mult and for reserved opcodes
function automatic logic [31:0] model_alu(input logic [4:0] op, input logic [31:0] a,
	input logic [31:0] b, input logic [4:0] sa);
	case (op)
		ex_types_pkg::alu_add, ex_types_pkg::alu_addu: return a + b;
		ex_types_pkg::alu_sub, ex_types_pkg::alu_subu: return a - b;
		ex_types_pkg::alu_and:    return a & b;
		ex_types_pkg::alu_or:     return a | b;
		ex_types_pkg::alu_xor:    return a ^ b;
		ex_types_pkg::alu_nor:    return ~(a | b);
		ex_types_pkg::alu_slt:    return {31'd0, $signed(a) < $signed(b)};
		ex_types_pkg::alu_sltu:   return {31'd0, a < b};
		ex_types_pkg::alu_sll:    return b << sa;
		ex_types_pkg::alu_srl:    return b >> sa;
		ex_types_pkg::alu_sra:    return $signed(b) >>> sa;
		ex_types_pkg::alu_lui:    return b << 16;
		ex_types_pkg::alu_pass_b: return b;
		default:                  return 32'd0;
	endcase
endfunction

// expected exception code, decode first, then reserved opcode, then overflow
function automatic logic [4:0] model_exc(input logic [4:0] op, input logic [4:0] exc_in,
	input logic [31:0] a, input logic [31:0] b);
	logic [31:0] r;
	r = model_alu(op, a, b, 5'd0);
	if (exc_in != ex_types_pkg::exc_none) return exc_in;
	if (op > ex_types_pkg::alu_mult) return ex_types_pkg::exc_ri;
	if (op == ex_types_pkg::alu_add && a[31] == b[31] && r[31] != a[31])
		return ex_types_pkg::exc_ov;
	if (op == ex_types_pkg::alu_sub && a[31] != b[31] && r[31] != a[31])
		return ex_types_pkg::exc_ov;
	return ex_types_pkg::exc_none;
endfunction

function automatic logic model_branch_flag(input logic [1:0] bop, input logic [31:0] r);
	return (bop == ex_types_pkg::br_eqz && r == 32'd0) ||
		(bop == ex_types_pkg::br_nez && r != 32'd0) || (bop == ex_types_pkg::br_uncond);
endfunction

function automatic logic [31:0] model_branch_dest(input logic use_reg, input logic [31:0] dest,
	input logic [31:0] reg2);
	return use_reg ? reg2 : dest;
endfunction

// full unsigned product, hi in the upper word
function automatic logic [63:0] model_mult(input logic [31:0] a, input logic [31:0] b);
	return {32'd0, a} * {32'd0, b};
endfunction

`endif

// File: testbench/tb_ex_subsystem.sv
// testbench for ex_subsystem, replays testbench/ex_stim.txt and then sweeps random multiplies
`timescale 1ns/1ps

module tb_ex_subsystem;

	localparam int data_width = 32;
	localparam int n_fields   = 22; // hex words per stimulus line
	localparam int max_vec    = 64;
	localparam int n_sweep    = 20;

	logic                  clk;
	logic                  rst_n;
	logic                  stall;
	logic                  clear;
	ex_pipe_pkg::id2ex_t   id2ex;
	logic [data_width-1:0] reg1_data;
	logic [data_width-1:0] reg2_data;
	logic                  branch_flag;
	logic [data_width-1:0] branch_dest;
	ex_pipe_pkg::ex2mem_t  ex2mem;
	logic [31:0]           hi;
	logic [31:0]           lo;
	logic                  mult_busy;

	logic [31:0] stim [0:max_vec*n_fields-1];
	int          n_vec;
	bit          loaded;
	int          value_errors;
	int          stim_errors;
	int          proto_errors;

	// expected state, it holds under stall the way ex2mem does
	logic [31:0] exp_res;
	logic [4:0]  exp_exc;
	logic [2:0]  exp_mem_op;
	logic [4:0]  exp_wb;
	logic [31:0] exp_bva;
	logic [31:0] exp_epc;
	logic [31:0] exp_mdata; // store data is reg2 of the last accepted instruction
	logic        exp_bf;
	logic [31:0] exp_bd;
	logic [63:0] exp_prod;
	logic        exp_start; // a multiply was handed to the multiplier

	ex_subsystem #(.data_width(data_width)) i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.stall       (stall),
		.clear       (clear),
		.id2ex       (id2ex),
		.reg1_data   (reg1_data),
		.reg2_data   (reg2_data),
		.branch_flag (branch_flag),
		.branch_dest (branch_dest),
		.ex2mem      (ex2mem),
		.hi          (hi),
		.lo          (lo),
		.mult_busy   (mult_busy)
	);

	`include "tb_ex_model.svh"

	always #10 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			value_errors++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// the file and the model must agree before the DUT is judged
	task automatic check_stim(input string name, input logic [31:0] model, input logic [31:0] file);
		assert (file === model) else begin
			stim_errors++;
			$display("ERROR %s in stimulus file: expected %h by the model, actual %h", name,
				model, file);
		end
	endtask

	task automatic print_counts();
		$display("errors: %0d value, %0d stimulus, %0d handshake", value_errors, stim_errors,
			proto_errors);
	endtask

	task automatic drive_vector(input int v);
		int b;
		b = v * n_fields;
		id2ex.alu_op          = ex_types_pkg::alu_op_e'(stim[b+1][4:0]);
		id2ex.alu_src_imm     = stim[b+2][0];
		id2ex.sa_imm          = stim[b+3];
		id2ex.branch_op       = ex_types_pkg::branch_op_e'(stim[b+4][1:0]);
		id2ex.branch_dest     = stim[b+5];
		id2ex.branch_dest_reg = stim[b+6][0];
		id2ex.mem_op          = ex_types_pkg::mem_op_e'(stim[b+7][2:0]);
		id2ex.wb_addr         = stim[b+8][4:0];
		id2ex.exc_code        = ex_types_pkg::exc_code_e'(stim[b+9][4:0]);
		id2ex.exc_epc         = stim[b+10];
		id2ex.exc_badvaddr    = stim[b+11];
		reg1_data             = stim[b+12];
		reg2_data             = stim[b+13];
		stall                 = stim[b+14][0];
		clear                 = stim[b+15][0];
	endtask

	// advances the expected state by one edge with the inputs now driven
	task automatic update_model();
		logic [31:0] opb;
		logic [31:0] r;
		logic [4:0]  e;
		opb = id2ex.alu_src_imm ? id2ex.sa_imm : reg2_data;
		r = model_alu(id2ex.alu_op, reg1_data, opb, id2ex.sa_imm[4:0]);
		e = model_exc(id2ex.alu_op, id2ex.exc_code, reg1_data, opb);
		exp_bf = model_branch_flag(id2ex.branch_op, r);
		exp_bd = model_branch_dest(id2ex.branch_dest_reg, id2ex.branch_dest, reg2_data);
		exp_start = 1'b0;
		if (!stall && clear) begin // bubble, the data fields keep their old values
			exp_exc    = ex_types_pkg::exc_none;
			exp_mem_op = ex_types_pkg::mem_none;
			exp_wb     = 5'd0;
		end else if (!stall) begin
			exp_res    = r;
			exp_exc    = e;
			exp_mem_op = (e == ex_types_pkg::exc_none) ? id2ex.mem_op : ex_types_pkg::mem_none;
			exp_wb     = (e == ex_types_pkg::exc_none) ? id2ex.wb_addr : 5'd0;
			exp_bva    = id2ex.exc_badvaddr;
			exp_epc    = id2ex.exc_epc;
			exp_mdata  = reg2_data;
			if (e == ex_types_pkg::exc_ri && id2ex.exc_code == ex_types_pkg::exc_none)
				exp_bva = {ex_types_pkg::ri_badvaddr_tag, 23'd0, id2ex.alu_op};
			if (id2ex.alu_op == ex_types_pkg::alu_mult && e == ex_types_pkg::exc_none) begin
				exp_prod  = model_mult(reg1_data, reg2_data);
				exp_start = 1'b1;
			end
		end
	endtask

	task automatic check_vector(input int v, input string t);
		int b;
		b = v * n_fields;
		check_stim({t, " alu_result"}, exp_res, stim[b+16]);
		check_stim({t, " exc_code"}, 32'(exp_exc), stim[b+17]);
		check_stim({t, " branch_flag"}, 32'(exp_bf), stim[b+18]);
		check_stim({t, " branch_dest"}, exp_bd, stim[b+19]);
		check_stim({t, " hi"}, exp_prod[63:32], stim[b+20]);
		check_stim({t, " lo"}, exp_prod[31:0], stim[b+21]);
		check_value({t, " alu_result"}, stim[b+16], ex2mem.alu_result);
		check_value({t, " mem_addr"}, stim[b+16], ex2mem.mem_addr);
		check_value({t, " mem_data"}, exp_mdata, ex2mem.mem_data);
		check_value({t, " exc_epc"}, exp_epc, ex2mem.exc_epc);
		check_value({t, " exc_code"}, stim[b+17], 32'(ex2mem.exc_code));
		check_value({t, " mem_op"}, 32'(exp_mem_op), 32'(ex2mem.mem_op));
		check_value({t, " wb_addr"}, 32'(exp_wb), 32'(ex2mem.wb_addr));
		if (exp_exc != ex_types_pkg::exc_none)
			check_value({t, " exc_badvaddr"}, exp_bva, ex2mem.exc_badvaddr);
		check_value({t, " branch_flag"}, stim[b+18], 32'(branch_flag));
		check_value({t, " branch_dest"}, stim[b+19], branch_dest);
	endtask

	// stalls the pipe and follows the multiplier handshake until mult_busy drops
	task automatic wait_mult(input string t);
		int n;
		#1;
		stall = 1'b1; // keeps the same mult from being taken again
		n = 0;
		while (!mult_busy && n < 2) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (mult_busy) else begin
			proto_errors++;
			$display("%s: mult_busy did not rise within 2 cycles of the multiply", t);
		end
		n = 0;
		while (mult_busy && n < data_width + 10) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (!mult_busy) else begin
			proto_errors++;
			$display("%s: multiplier handshake did not complete", t);
		end
	endtask

	initial begin
		int v;
		int i;
		string t;
		clk = 1'b0;
		rst_n = 1'b0;
		stall = 1'b0;
		clear = 1'b0;
		id2ex = '0;
		reg1_data = '0;
		reg2_data = '0;
		value_errors = 0;
		stim_errors = 0;
		proto_errors = 0;
		exp_res = '0;
		exp_exc = '0;
		exp_mem_op = '0;
		exp_wb = '0;
		exp_bva = '0;
		exp_epc = '0;
		exp_mdata = '0;
		exp_prod = '0;
		void'($urandom(39367));
		$readmemh("testbench/ex_stim.txt", stim);
		n_vec = 0;
		while (n_vec < max_vec && stim[n_vec*n_fields] != 32'd0)
			n_vec++;
		loaded = 1'b1;
		if (n_vec == 0) begin
			proto_errors++;
			$display("stimulus file is missing or holds no vectors");
		end
		repeat (2) @(posedge clk);
		#2;
		check_value("reset mem_op", 32'd0, 32'(ex2mem.mem_op));
		check_value("reset wb_addr", 32'd0, 32'(ex2mem.wb_addr));
		check_value("reset exc_code", 32'd0, 32'(ex2mem.exc_code));
		check_value("reset branch_flag", 32'd0, 32'(branch_flag));
		check_value("reset branch_dest", 32'd0, branch_dest);
		check_value("reset hi", 32'd0, hi);
		check_value("reset lo", 32'd0, lo);
		check_value("reset mult_busy", 32'd0, 32'(mult_busy));
		rst_n = 1'b1;
		for (v = 0; v < n_vec; v++) begin
			t = $sformatf("t%0h", stim[v*n_fields]);
			drive_vector(v);
			update_model();
			@(posedge clk);
			#1;
			check_vector(v, t);
			if (exp_start)
				wait_mult(t); // hi/lo only settle after the handshake
			check_value({t, " hi"}, stim[v*n_fields+20], hi);
			check_value({t, " lo"}, stim[v*n_fields+21], lo);
			#1;
		end
		for (i = 0; i < n_sweep; i++) begin
			t = $sformatf("sweep%0d", i);
			id2ex = '0;
			id2ex.alu_op = ex_types_pkg::alu_mult;
			reg1_data = $urandom;
			reg2_data = $urandom;
			stall = 1'b0;
			clear = 1'b0;
			update_model();
			@(posedge clk);
			#1;
			wait_mult(t);
			check_value({t, " hi"}, exp_prod[63:32], hi);
			check_value({t, " lo"}, exp_prod[31:0], lo);
			#1;
		end
		print_counts();
		if (value_errors + stim_errors + proto_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// every vector gets room for a full multiply handshake
	initial begin
		int cycles;
		wait (loaded);
		cycles = (n_vec + n_sweep + 4) * (data_width + 10);
		repeat (cycles) @(posedge clk);
		$display("watchdog: the run hung and did not finish within %0d cycles", cycles);
		print_counts();
		$display("Done: errors found");
		$finish;
	end

endmodule
